/* verilog/rename_pkg.sv */
// ====================
// Register counts and default widths for the rename stage
// The logical register count is fixed by the ISA
// Physical count must exceed ARCH_REG_NUM plus the group width
// ====================

package rename_pkg;

  // ====================
  // Architectural side
  // ====================

  // Logical registers r0..r31
  localparam int unsigned ARCH_REG_NUM = 32;

  // Logical register number
  typedef logic [4:0] lreg_t;

  // ====================
  // Defaults for the top level
  // ====================

  // Physical register file size, 6-bit tags at 64
  localparam int unsigned PHY_REG_NUM_DEF = 64;

  // Instructions renamed per cycle
  localparam int unsigned DECODE_WIDTH_DEF = 2;

  // Instructions retired per cycle
  localparam int unsigned COMMIT_WIDTH_DEF = 2;

endpackage : rename_pkg

/* verilog/rename_group_if.sv */
// ====================
// One rename group, one entry per decode slot
// Request and results live in the same cycle
// fire marks the edge where the group is taken
// ====================

`timescale 1ns/10ps

interface rename_group_if import rename_pkg::*; #(
  parameter int unsigned PHY_REG_NUM  = PHY_REG_NUM_DEF,
  parameter int unsigned DECODE_WIDTH = DECODE_WIDTH_DEF
) ();

  localparam int unsigned PREG_W = $clog2(PHY_REG_NUM);

  // Request from decode
  logic  [DECODE_WIDTH-1:0]             dest_valid;
  lreg_t [DECODE_WIDTH-1:0]             src0;
  lreg_t [DECODE_WIDTH-1:0]             src1;
  lreg_t [DECODE_WIDTH-1:0]             dest;

  // New physical destination per slot
  logic  [DECODE_WIDTH-1:0][PREG_W-1:0] preg;

  // Lookup results
  logic  [DECODE_WIDTH-1:0][PREG_W-1:0] psrc0;
  logic  [DECODE_WIDTH-1:0][PREG_W-1:0] psrc1;
  // Old mapping of dest, freed later by the ROB
  logic  [DECODE_WIDTH-1:0][PREG_W-1:0] ppdst;

  // Group accepted this cycle
  logic                                 fire;

  modport req (output dest_valid, src0, src1, dest, fire,
               input  preg, psrc0, psrc1, ppdst);

  modport alloc (input dest_valid, fire, output preg);

  modport rat (input  dest_valid, src0, src1, dest, preg, fire,
               output psrc0, psrc1, ppdst);

endinterface : rename_group_if

/* verilog/commit_if.sv */
// ====================
// Commit slots in program order
// A valid slot always carries a destination
// No back-pressure
// ====================

`timescale 1ns/10ps

interface commit_if import rename_pkg::*; #(
  parameter int unsigned PHY_REG_NUM  = PHY_REG_NUM_DEF,
  parameter int unsigned COMMIT_WIDTH = COMMIT_WIDTH_DEF
) ();

  localparam int unsigned PREG_W = $clog2(PHY_REG_NUM);

  logic  [COMMIT_WIDTH-1:0]             valid;
  lreg_t [COMMIT_WIDTH-1:0]             dest;
  // Committed mapping of dest
  logic  [COMMIT_WIDTH-1:0][PREG_W-1:0] preg;
  // Mapping it replaces, back to the free list
  logic  [COMMIT_WIDTH-1:0][PREG_W-1:0] ppdst;

  // Free list side
  modport rel (input valid, ppdst);

  // Architectural table side
  modport arch (input valid, dest, preg);

endinterface : commit_if

/* verilog/free_list.sv */
// ====================
// In-order circular free list of physical registers
// Holds PHY_REG_NUM minus 32 entries, full after reset
// Restore and commit never share a cycle
// ====================

`timescale 1ns/10ps

module free_list import rename_pkg::*; #(
  parameter int unsigned PHY_REG_NUM  = PHY_REG_NUM_DEF,
  parameter int unsigned DECODE_WIDTH = DECODE_WIDTH_DEF,
  parameter int unsigned COMMIT_WIDTH = COMMIT_WIDTH_DEF
) (
  input  logic           clk,
  input  logic           rst_n,
  rename_group_if.alloc  grp,
  commit_if.rel          cmt,
  input  logic           restore_i,
  output logic           ready_o
);

  localparam int unsigned PREG_W   = $clog2(PHY_REG_NUM);
  localparam int unsigned FL_DEPTH = PHY_REG_NUM - ARCH_REG_NUM;
  localparam int unsigned PTR_W    = $clog2(FL_DEPTH);
  localparam int unsigned CNT_W    = $clog2(FL_DEPTH + 1);

  // ====================
  // Storage and pointers
  // ====================

  logic [FL_DEPTH-1:0][PREG_W-1:0] fl_mem;
  // Speculative head that moves at rename
  logic [PTR_W-1:0]                head_q;
  // Head as seen by retired work only
  logic [PTR_W-1:0]                cmt_head_q;
  logic [PTR_W-1:0]                tail_q;
  logic [CNT_W-1:0]                count_q;
  logic [CNT_W-1:0]                count_n;

  logic [DECODE_WIDTH-1:0][PTR_W-1:0]  alloc_idx;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] alloc_preg;
  logic [CNT_W-1:0]                    alloc_num;
  logic [COMMIT_WIDTH-1:0][PTR_W-1:0]  rel_idx;
  logic [CNT_W-1:0]                    rel_num;

  // Pointer add with wrap for a depth that need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                               input int unsigned n);
    int unsigned sum;
    sum = ptr + n;
    if (sum >= FL_DEPTH) begin
      sum = sum - FL_DEPTH;
    end
    return sum[PTR_W-1:0];
  endfunction

  // ====================
  // Allocation side
  // ====================

  // Slots with a dest take consecutive head entries in slot order
  always_comb begin
    alloc_num = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      alloc_idx[i] = ptr_add(head_q, alloc_num);
      if (grp.dest_valid[i]) begin
        alloc_preg[i] = fl_mem[alloc_idx[i]];
        alloc_num     = alloc_num + 1'b1;
      end else begin
        // Nothing handed out to a slot without a dest
        alloc_preg[i] = '0;
      end
    end
  end

  assign grp.preg = alloc_preg;

  // Full group must fit and nothing issues during a flush
  assign ready_o = (count_q >= CNT_W'(DECODE_WIDTH)) && !restore_i;

  // ====================
  // Release side
  // ====================

  always_comb begin
    rel_num = '0;
    for (int c = 0; c < COMMIT_WIDTH; c++) begin
      rel_idx[c] = ptr_add(tail_q, rel_num);
      if (cmt.valid[c]) begin
        rel_num = rel_num + 1'b1;
      end
    end
  end

  // After a flush every non-architectural register is free again
  always_comb begin
    if (restore_i) begin
      count_n = CNT_W'(FL_DEPTH);
    end else begin
      count_n = count_q + rel_num;
      if (grp.fire) begin
        count_n = count_n - alloc_num;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Registers 32 and up start out free
      for (int e = 0; e < FL_DEPTH; e++) begin
        fl_mem[e] <= PREG_W'(ARCH_REG_NUM + e);
      end
      head_q     <= '0;
      cmt_head_q <= '0;
      tail_q     <= '0;
      count_q    <= CNT_W'(FL_DEPTH);
    end else begin
      for (int c = 0; c < COMMIT_WIDTH; c++) begin
        if (cmt.valid[c]) begin
          fl_mem[rel_idx[c]] <= cmt.ppdst[c];
        end
      end
      if (restore_i) begin
        head_q <= cmt_head_q;
      end else if (grp.fire) begin
        head_q <= ptr_add(head_q, alloc_num);
      end
      // Each retired dest consumed one entry at rename
      cmt_head_q <= ptr_add(cmt_head_q, rel_num);
      tail_q     <= ptr_add(tail_q, rel_num);
      count_q    <= count_n;
    end
  end

  // ====================
  // Checks
  // ====================

  // Releases can never overfill the list
  a_count_cap: assert property (@(posedge clk) disable iff (!rst_n)
    count_q <= CNT_W'(FL_DEPTH));

endmodule : free_list

/* verilog/register_alias_table.sv */
// ====================
// Speculative logical to physical map
// Lookups are combinational and writes land at the fire edge
// Restore loads the committed map and wins over a write
// ====================

`timescale 1ns/10ps

module register_alias_table import rename_pkg::*; #(
  parameter int unsigned PHY_REG_NUM  = PHY_REG_NUM_DEF,
  parameter int unsigned DECODE_WIDTH = DECODE_WIDTH_DEF,
  localparam int unsigned PREG_W      = $clog2(PHY_REG_NUM)
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  rename_group_if.rat                          grp,
  input  logic                                 restore_i,
  input  logic [ARCH_REG_NUM-1:0][PREG_W-1:0]  arch_rat_i
);

  logic [ARCH_REG_NUM-1:0][PREG_W-1:0] rat_q;
  logic [ARCH_REG_NUM-1:0][PREG_W-1:0] rat_n;
  logic [DECODE_WIDTH-1:0]             wen;

  // ====================
  // Lookup with in-group bypass
  // ====================

  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      grp.psrc0[i] = rat_q[grp.src0[i]];
      grp.psrc1[i] = rat_q[grp.src1[i]];
      grp.ppdst[i] = rat_q[grp.dest[i]];
      // Older slots first so the nearest writer ends up on top
      for (int j = 0; j < i; j++) begin
        if (grp.dest_valid[j] && (grp.dest[j] == grp.src0[i])) begin
          grp.psrc0[i] = grp.preg[j];
        end
        if (grp.dest_valid[j] && (grp.dest[j] == grp.src1[i])) begin
          grp.psrc1[i] = grp.preg[j];
        end
        // Old mapping is the preg of an earlier slot with the same dest
        if (grp.dest_valid[j] && (grp.dest[j] == grp.dest[i])) begin
          grp.ppdst[i] = grp.preg[j];
        end
      end
    end
  end

  // ====================
  // WAW masking and next state
  // ====================

  // Only the youngest writer of a register updates the map
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      wen[i] = grp.fire && grp.dest_valid[i];
      for (int j = i + 1; j < DECODE_WIDTH; j++) begin
        if (grp.dest_valid[j] && (grp.dest[j] == grp.dest[i])) begin
          wen[i] = 1'b0;
        end
      end
    end
  end

  always_comb begin
    if (restore_i) begin
      rat_n = arch_rat_i;
    end else begin
      rat_n = rat_q;
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        if (wen[i]) begin
          rat_n[grp.dest[i]] = grp.preg[i];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity map from r to pr
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        rat_q[r] <= PREG_W'(r);
      end
    end else begin
      rat_q <= rat_n;
    end
  end

  // ====================
  // Checks
  // ====================

  // True when some logical register maps to p
  function automatic logic is_mapped(input logic [ARCH_REG_NUM-1:0][PREG_W-1:0] map,
                                     input logic [PREG_W-1:0] p);
    logic hit;
    hit = 1'b0;
    for (int r = 0; r < ARCH_REG_NUM; r++) begin
      if (map[r] == p) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // A double free upstream would hand out a register that is still live
  for (genvar g = 0; g < DECODE_WIDTH; g++) begin : g_fresh_chk
    a_preg_unmapped: assert property (@(posedge clk) disable iff (!rst_n)
      (grp.fire && grp.dest_valid[g]) |-> !is_mapped(rat_q, grp.preg[g]));
  end

endmodule : register_alias_table

/* verilog/arch_alias_table.sv */
// ====================
// Committed logical to physical map
// Written at commit, read whole for a flush
// ====================

`timescale 1ns/10ps

module arch_alias_table import rename_pkg::*; #(
  parameter int unsigned PHY_REG_NUM  = PHY_REG_NUM_DEF,
  parameter int unsigned COMMIT_WIDTH = COMMIT_WIDTH_DEF,
  localparam int unsigned PREG_W      = $clog2(PHY_REG_NUM)
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  commit_if.arch                               cmt,
  input  logic                                 restore_i,
  output logic [ARCH_REG_NUM-1:0][PREG_W-1:0]  arch_rat_o
);

  logic [ARCH_REG_NUM-1:0][PREG_W-1:0] rat_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        rat_q[r] <= PREG_W'(r);
      end
    end else begin
      // Later slot is younger, last write wins
      for (int c = 0; c < COMMIT_WIDTH; c++) begin
        if (cmt.valid[c]) begin
          rat_q[cmt.dest[c]] <= cmt.preg[c];
        end
      end
    end
  end

  // Whole map goes to the speculative table
  assign arch_rat_o = rat_q;

  // A commit in the flush cycle would be lost by the free list rollback
  a_no_commit_on_restore: assert property (@(posedge clk) disable iff (!rst_n)
    !(restore_i && |cmt.valid));

endmodule : arch_alias_table

/* verilog/rename_stage.sv */
// ====================
// Register rename stage, top level
// Results are combinational, group taken when valid and ready
// Source holds its group while ready_o is low
// restore_i is a one-cycle pulse, never with a commit
// ====================

`timescale 1ns/10ps

module rename_stage import rename_pkg::*; #(
  parameter int unsigned PHY_REG_NUM  = PHY_REG_NUM_DEF,
  parameter int unsigned DECODE_WIDTH = DECODE_WIDTH_DEF,
  parameter int unsigned COMMIT_WIDTH = COMMIT_WIDTH_DEF,
  localparam int unsigned PREG_W      = $clog2(PHY_REG_NUM)
) (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // Rename group
  input  logic                                 group_valid_i,
  input  logic  [DECODE_WIDTH-1:0]             dest_valid_i,
  input  lreg_t [DECODE_WIDTH-1:0]             src0_i,
  input  lreg_t [DECODE_WIDTH-1:0]             src1_i,
  input  lreg_t [DECODE_WIDTH-1:0]             dest_i,

  // Commit slots
  input  logic  [COMMIT_WIDTH-1:0]             commit_valid_i,
  input  lreg_t [COMMIT_WIDTH-1:0]             commit_dest_i,
  input  logic  [COMMIT_WIDTH-1:0][PREG_W-1:0] commit_preg_i,
  input  logic  [COMMIT_WIDTH-1:0][PREG_W-1:0] commit_ppdst_i,

  // Flush back to committed state
  input  logic                                 restore_i,

  output logic                                 ready_o,
  output logic  [DECODE_WIDTH-1:0][PREG_W-1:0] psrc0_o,
  output logic  [DECODE_WIDTH-1:0][PREG_W-1:0] psrc1_o,
  output logic  [DECODE_WIDTH-1:0][PREG_W-1:0] pdst_o,
  output logic  [DECODE_WIDTH-1:0][PREG_W-1:0] ppdst_o
);

  logic [ARCH_REG_NUM-1:0][PREG_W-1:0] arch_rat;

  rename_group_if #(
    .PHY_REG_NUM  (PHY_REG_NUM),
    .DECODE_WIDTH (DECODE_WIDTH)
  ) grp_if ();

  commit_if #(
    .PHY_REG_NUM  (PHY_REG_NUM),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) cmt_if ();

  // ====================
  // Port to interface
  // ====================

  assign grp_if.dest_valid = dest_valid_i;
  assign grp_if.src0       = src0_i;
  assign grp_if.src1       = src1_i;
  assign grp_if.dest       = dest_i;
  // Handshake edge
  assign grp_if.fire       = group_valid_i && ready_o;

  assign cmt_if.valid = commit_valid_i;
  assign cmt_if.dest  = commit_dest_i;
  assign cmt_if.preg  = commit_preg_i;
  assign cmt_if.ppdst = commit_ppdst_i;

  assign psrc0_o = grp_if.psrc0;
  assign psrc1_o = grp_if.psrc1;
  // Freshly allocated register is the new dest
  assign pdst_o  = grp_if.preg;
  assign ppdst_o = grp_if.ppdst;

  // ====================
  // Stores
  // ====================

  free_list #(
    .PHY_REG_NUM  (PHY_REG_NUM),
    .DECODE_WIDTH (DECODE_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_free_list (
    .clk       (clk),
    .rst_n     (rst_n),
    .grp       (grp_if.alloc),
    .cmt       (cmt_if.rel),
    .restore_i (restore_i),
    .ready_o   (ready_o)
  );

  register_alias_table #(
    .PHY_REG_NUM  (PHY_REG_NUM),
    .DECODE_WIDTH (DECODE_WIDTH)
  ) u_rat (
    .clk        (clk),
    .rst_n      (rst_n),
    .grp        (grp_if.rat),
    .restore_i  (restore_i),
    .arch_rat_i (arch_rat)
  );

  arch_alias_table #(
    .PHY_REG_NUM  (PHY_REG_NUM),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_arch_rat (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmt        (cmt_if.arch),
    .restore_i  (restore_i),
    .arch_rat_o (arch_rat)
  );

endmodule : rename_stage

/* verif/rename_stage_tb.sv */
// ====================
// Trace-driven testbench for the rename stage
// Runs at the default widths, two rename and two commit slots
// Trace path is relative to the project root
// ====================

`timescale 1ns/10ps

module rename_stage_tb import rename_pkg::*; ();

  localparam int unsigned PHY_REG_NUM   = PHY_REG_NUM_DEF;
  localparam int unsigned DECODE_WIDTH  = DECODE_WIDTH_DEF;
  localparam int unsigned COMMIT_WIDTH  = COMMIT_WIDTH_DEF;
  localparam int unsigned PREG_W        = $clog2(PHY_REG_NUM);
  // Cycles allowed for ready_o after reset
  localparam int unsigned READY_TIMEOUT = 50;
  // Expected columns per trace line
  localparam int unsigned NUM_FIELDS    = 9;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 group_valid;
  logic  [DECODE_WIDTH-1:0]             dest_valid;
  lreg_t [DECODE_WIDTH-1:0]             src0;
  lreg_t [DECODE_WIDTH-1:0]             src1;
  lreg_t [DECODE_WIDTH-1:0]             dest;
  logic  [COMMIT_WIDTH-1:0]             commit_valid;
  lreg_t [COMMIT_WIDTH-1:0]             commit_dest;
  logic  [COMMIT_WIDTH-1:0][PREG_W-1:0] commit_preg;
  logic  [COMMIT_WIDTH-1:0][PREG_W-1:0] commit_ppdst;
  logic                                 restore;
  logic                                 ready;
  logic  [DECODE_WIDTH-1:0][PREG_W-1:0] psrc0;
  logic  [DECODE_WIDTH-1:0][PREG_W-1:0] psrc1;
  logic  [DECODE_WIDTH-1:0][PREG_W-1:0] pdst;
  logic  [DECODE_WIDTH-1:0][PREG_W-1:0] ppdst;

  int checks;
  int errors;
  int num_tests;
  int test_checks;
  int test_errors;

  // Same order as the expected columns of the trace
  string field_name [NUM_FIELDS] = '{"ready_o", "psrc0_o[0]", "psrc1_o[0]", "pdst_o[0]",
    "ppdst_o[0]", "psrc0_o[1]", "psrc1_o[1]", "pdst_o[1]", "ppdst_o[1]"};

  rename_stage #(
    .PHY_REG_NUM  (PHY_REG_NUM),
    .DECODE_WIDTH (DECODE_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .group_valid_i  (group_valid),
    .dest_valid_i   (dest_valid),
    .src0_i         (src0),
    .src1_i         (src1),
    .dest_i         (dest),
    .commit_valid_i (commit_valid),
    .commit_dest_i  (commit_dest),
    .commit_preg_i  (commit_preg),
    .commit_ppdst_i (commit_ppdst),
    .restore_i      (restore),
    .ready_o        (ready),
    .psrc0_o        (psrc0),
    .psrc1_o        (psrc1),
    .pdst_o         (pdst),
    .ppdst_o        (ppdst)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================
  // Check helpers
  // ====================

  task automatic compare(input string test, input string field,
                         input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    test_checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("Error %s %s: expected %0d, actual %0d", test, field, expected, actual);
    end
  endtask

  // One summary line per finished test
  task automatic close_test(input string test);
    num_tests++;
    $display("test %-12s %0d checks, %0d errors", test, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // ====================
  // Trace replay
  // ====================

  // One line per cycle, drive at the rising edge, sample at the falling one
  task automatic replay_trace(input int fd);
    string       line;
    string       test;
    string       prev_test;
    string       op;
    int          n;
    int          in_val [14];
    string       exp_tok [NUM_FIELDS];
    logic [31:0] act [NUM_FIELDS];
    prev_test = "";
    while ($fgets(line, fd) != 0) begin
      // Blank lines and column notes
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %s %s %s %s %s %s %s %s %s",
        test, op, in_val[0], in_val[1], in_val[2], in_val[3], in_val[4], in_val[5],
        in_val[6], in_val[7], in_val[8], in_val[9], in_val[10], in_val[11], in_val[12],
        in_val[13], exp_tok[0], exp_tok[1], exp_tok[2], exp_tok[3], exp_tok[4],
        exp_tok[5], exp_tok[6], exp_tok[7], exp_tok[8]);
      if (n != 25) begin
        $display("A trace line could not be parsed: %s", line);
        errors++;
        continue;
      end
      if (test != prev_test) begin
        if (prev_test != "") begin
          close_test(prev_test);
        end
        prev_test = test;
      end
      @(posedge clk);
      group_valid     <= (op == "R");
      restore         <= (op == "F");
      dest_valid      <= DECODE_WIDTH'(in_val[0]);
      src0[0]         <= lreg_t'(in_val[1]);
      src1[0]         <= lreg_t'(in_val[2]);
      dest[0]         <= lreg_t'(in_val[3]);
      src0[1]         <= lreg_t'(in_val[4]);
      src1[1]         <= lreg_t'(in_val[5]);
      dest[1]         <= lreg_t'(in_val[6]);
      // Commit slots only count on commit lines
      commit_valid    <= (op == "C") ? COMMIT_WIDTH'(in_val[7]) : '0;
      commit_dest[0]  <= lreg_t'(in_val[8]);
      commit_preg[0]  <= PREG_W'(in_val[9]);
      commit_ppdst[0] <= PREG_W'(in_val[10]);
      commit_dest[1]  <= lreg_t'(in_val[11]);
      commit_preg[1]  <= PREG_W'(in_val[12]);
      commit_ppdst[1] <= PREG_W'(in_val[13]);
      @(negedge clk);
      act[0] = 32'(ready);
      act[1] = 32'(psrc0[0]);
      act[2] = 32'(psrc1[0]);
      act[3] = 32'(pdst[0]);
      act[4] = 32'(ppdst[0]);
      act[5] = 32'(psrc0[1]);
      act[6] = 32'(psrc1[1]);
      act[7] = 32'(pdst[1]);
      act[8] = 32'(ppdst[1]);
      for (int f = 0; f < NUM_FIELDS; f++) begin
        // x in the trace means don't care
        if (exp_tok[f] != "x") begin
          compare(test, field_name[f], exp_tok[f].atoi(), act[f]);
        end
      end
    end
    if (prev_test != "") begin
      close_test(prev_test);
    end
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    int fd;
    int wait_cnt;
    checks       = 0;
    errors       = 0;
    num_tests    = 0;
    test_checks  = 0;
    test_errors  = 0;
    rst_n        = 1'b0;
    group_valid  = 1'b0;
    dest_valid   = '0;
    src0         = '0;
    src1         = '0;
    dest         = '0;
    commit_valid = '0;
    commit_dest  = '0;
    commit_preg  = '0;
    commit_ppdst = '0;
    restore      = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    // ready_o should be up in the first cycle out of reset
    wait_cnt = 0;
    @(negedge clk);
    while (ready !== 1'b1 && wait_cnt < READY_TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (ready !== 1'b1) begin
      $display("ready_o stayed low for %0d cycles after reset", READY_TIMEOUT);
      errors++;
    end else begin
      fd = $fopen("verif/rename_trace.txt", "r");
      if (fd == 0) begin
        $display("The trace file verif/rename_trace.txt could not be opened");
        errors++;
      end else begin
        replay_trace(fd);
        $fclose(fd);
      end
    end
    $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : rename_stage_tb

/* verif/rename_trace.txt */
# test op dv src0[0] src1[0] dest[0] src0[1] src1[1] dest[1] cv cdest0 cpreg0 cppdst0 cdest1 cpreg1 cppdst1
#   then expected: ready psrc0[0] psrc1[0] pdst[0] ppdst[0] psrc0[1] psrc1[1] pdst[1] ppdst[1]
# op R rename, C commit, F restore, I idle; dv and cv are slot masks; x is don't care
reset_map    I 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 x x x x x x x x
reset_map    R 1 1 2 3 0 0 0 0 0 0 0 0 0 0 1 1 2 32 3 x x x x
reset_map    R 1 3 3 4 0 0 0 0 0 0 0 0 0 0 1 32 32 33 4 x x x x
bypass       R 3 1 2 5 5 3 5 0 0 0 0 0 0 0 1 1 2 34 5 34 32 35 34
bypass       R 1 5 4 6 0 0 0 0 0 0 0 0 0 0 1 35 33 36 6 x x x x
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 7 8 37 7 37 8 38 8
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 37 38 39 37 39 38 40 38
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 39 40 41 39 41 40 42 40
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 41 42 43 41 43 42 44 42
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 43 44 45 43 45 44 46 44
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 45 46 47 45 47 46 48 46
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 47 48 49 47 49 48 50 48
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 49 50 51 49 51 50 52 50
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 51 52 53 51 53 52 54 52
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 53 54 55 53 55 54 56 54
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 55 56 57 55 57 56 58 56
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 57 58 59 57 59 58 60 58
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 1 59 60 61 59 61 60 62 60
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 0 61 62 63 61 63 62 x 62
backpressure R 3 7 8 7 7 8 8 0 0 0 0 0 0 0 0 61 62 63 61 63 62 x 62
commit       C 0 0 0 0 0 0 0 3 3 32 3 4 33 4 0 x x x x x x x x
commit       C 0 0 0 0 0 0 0 3 5 34 5 5 35 34 1 x x x x x x x x
commit       R 3 3 5 9 9 0 10 0 0 0 0 0 0 0 1 32 35 63 9 63 0 3 10
commit       R 3 10 9 11 11 12 12 0 0 0 0 0 0 0 1 3 63 4 11 4 12 5 12
restore      F 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 x x x x x x x x
restore      R 0 6 7 0 8 9 0 0 0 0 0 0 0 0 1 6 7 x x 8 9 x x
restore      R 0 10 11 0 12 5 0 0 0 0 0 0 0 0 1 10 11 x x 12 35 x x
restore      R 1 3 4 13 0 0 0 0 0 0 0 0 0 0 1 32 33 36 13 x x x x

/* files.f */
verilog/rename_pkg.sv
verilog/rename_group_if.sv
verilog/commit_if.sv
verilog/free_list.sv
verilog/register_alias_table.sv
verilog/arch_alias_table.sv
verilog/rename_stage.sv
verif/rename_stage_tb.sv

/* Bender.yml */
package:
  name: rename_stage

sources:
  - verilog/rename_pkg.sv
  - verilog/rename_group_if.sv
  - verilog/commit_if.sv
  - verilog/free_list.sv
  - verilog/register_alias_table.sv
  - verilog/arch_alias_table.sv
  - verilog/rename_stage.sv
  - target: test
    files:
      - verif/rename_stage_tb.sv
